// File: gpgpu_mem.f
hw/l2_pkg.sv
hw/perf_pkg.sv
hw/l2_req_if.sv
hw/l2_arbiter.sv
hw/l2_memory_stage.sv
hw/perf_counters.sv
hw/gpgpu_mem_top.sv
tests/gpgpu_mem_tb.sv

// File: hw/gpgpu_mem_top.sv
`timescale 1ns/1ps

module gpgpu_mem_top
(
	input logic clk,
	input logic reset,

	// Core 0 request
	input logic req_valid0,
	input l2_pkg::l2_op_t req_op0,
	input l2_pkg::l2_addr_t req_address0,
	input l2_pkg::l2_data_t req_data0,
	output logic req_ready0,

	// Core 1 request
	input logic req_valid1,
	input l2_pkg::l2_op_t req_op1,
	input l2_pkg::l2_addr_t req_address1,
	input l2_pkg::l2_data_t req_data1,
	output logic req_ready1,

	// Shared response
	output logic rsp_valid,
	output l2_pkg::l2_core_t rsp_core,
	output l2_pkg::l2_op_t rsp_op,
	output l2_pkg::l2_addr_t rsp_address,
	output l2_pkg::l2_data_t rsp_data,

	// Counter read
	input perf_pkg::perf_index_t perf_index,
	output perf_pkg::perf_count_t perf_value
);

	l2_req_if req_link(); // Arbiter to memory stage

	logic wait0; // Core 0 held off
	logic wait1; // Core 1 held off
	logic ev_load; // Load answered
	logic ev_store; // Store answered
	logic [perf_pkg::NUM_COUNTERS-1:0] events; // Counter inputs by index

	l2_arbiter l2_arbiter_i
	(
		.clk(clk),
		.reset(reset),
		.req_valid0(req_valid0),
		.req_op0(req_op0),
		.req_address0(req_address0),
		.req_data0(req_data0),
		.req_ready0(req_ready0),
		.req_valid1(req_valid1),
		.req_op1(req_op1),
		.req_address1(req_address1),
		.req_data1(req_data1),
		.req_ready1(req_ready1),
		.wait0(wait0),
		.wait1(wait1),
		.req(req_link.stage_out)
	);

	l2_memory_stage l2_memory_stage_i
	(
		.clk(clk),
		.reset(reset),
		.req(req_link.stage_in),
		.rsp_valid(rsp_valid),
		.rsp_core(rsp_core),
		.rsp_op(rsp_op),
		.rsp_address(rsp_address),
		.rsp_data(rsp_data),
		.ev_load(ev_load),
		.ev_store(ev_store)
	);

	// Place each event at its counter index
	assign events[perf_pkg::EV_LOAD] = ev_load;
	assign events[perf_pkg::EV_STORE] = ev_store;
	assign events[perf_pkg::EV_WAIT0] = wait0;
	assign events[perf_pkg::EV_WAIT1] = wait1;

	perf_counters perf_counters_i
	(
		.clk(clk),
		.reset(reset),
		.events(events),
		.perf_index(perf_index),
		.perf_value(perf_value)
	);

endmodule

// File: hw/l2_arbiter.sv
`timescale 1ns/1ps

module l2_arbiter
(
	input logic clk,
	input logic reset,

	// Core 0 request
	input logic req_valid0,
	input l2_pkg::l2_op_t req_op0,
	input l2_pkg::l2_addr_t req_address0,
	input l2_pkg::l2_data_t req_data0,
	output logic req_ready0,

	// Core 1 request
	input logic req_valid1,
	input l2_pkg::l2_op_t req_op1,
	input l2_pkg::l2_addr_t req_address1,
	input l2_pkg::l2_data_t req_data1,
	output logic req_ready1,

	// Wait events for the counters
	output logic wait0,
	output logic wait1,

	l2_req_if.stage_out req
);

	l2_pkg::l2_core_t prio_core; // Core that wins when both ask
	l2_pkg::l2_core_t grant_core; // Core taken this cycle
	logic grant; // Some core taken this cycle

	// A lone requester always wins, a tie goes to prio_core
	always_comb
	begin
		req_ready0 = req_valid0 && (!req_valid1 || prio_core == 1'b0);
		req_ready1 = req_valid1 && (!req_valid0 || prio_core == 1'b1);
	end

	assign grant = req_ready0 || req_ready1;
	assign grant_core = l2_pkg::l2_core_t'(req_ready1); // Ready is one-hot

	// Valid but not ready means held off
	assign wait0 = req_valid0 && !req_ready0;
	assign wait1 = req_valid1 && !req_ready1;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			prio_core <= '0; // Core 0 first
			req.valid <= 1'b0;
		end
		else
		begin
			req.valid <= grant; // One strobe per accepted request
			if (grant)
				prio_core <= ~grant_core; // Loser of this round goes next
		end
	end

	// Payload of the granted core, held only by the strobe
	always_ff @(posedge clk)
	begin
		if (grant)
		begin
			req.core <= grant_core;
			req.op <= req_ready1 ? req_op1 : req_op0;
			req.address <= req_ready1 ? req_address1 : req_address0;
			req.data <= req_ready1 ? req_data1 : req_data0;
		end
	end

endmodule

// File: hw/l2_memory_stage.sv
`timescale 1ns/1ps

module l2_memory_stage
(
	input logic clk,
	input logic reset,

	l2_req_if.stage_in req,

	// Response bus seen by every core
	output logic rsp_valid,
	output l2_pkg::l2_core_t rsp_core,
	output l2_pkg::l2_op_t rsp_op,
	output l2_pkg::l2_addr_t rsp_address,
	output l2_pkg::l2_data_t rsp_data,

	// Events for the counters
	output logic ev_load,
	output logic ev_store
);

	l2_pkg::l2_data_t mem [l2_pkg::MEM_WORDS]; // Shared word memory
	logic is_store; // Incoming request writes

	assign is_store = req.op == l2_pkg::OP_STORE;

	// Write port
	always_ff @(posedge clk)
	begin
		if (req.valid && is_store)
			mem[req.address] <= req.data;
	end

	// Response strobe, one cycle per request
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= req.valid;
	end

	// Response payload
	always_ff @(posedge clk)
	begin
		if (req.valid)
		begin
			rsp_core <= req.core; // Tag so each core can pick its own
			rsp_op <= req.op;
			rsp_address <= req.address;
			// Stores echo their data, loads return the stored word
			rsp_data <= is_store ? req.data : mem[req.address];
		end
	end

	// Events ride along with the response
	assign ev_load = rsp_valid && rsp_op == l2_pkg::OP_LOAD;
	assign ev_store = rsp_valid && rsp_op == l2_pkg::OP_STORE;

endmodule

// File: hw/l2_pkg.sv
package l2_pkg;

	// Shared level sizes
	localparam int NUM_CORES = 2; // Cores sharing the memory
	localparam int MEM_WORDS = 256; // On-chip word memory depth
	localparam int DATA_WIDTH = 32; // One memory word

	// Request and response fields
	typedef logic [$clog2(MEM_WORDS)-1:0] l2_addr_t; // Word address
	typedef logic [DATA_WIDTH-1:0] l2_data_t; // Data word
	typedef logic [$clog2(NUM_CORES)-1:0] l2_core_t; // Core index, tags the response
	typedef logic l2_op_t; // Load or store

	// Operation codes
	localparam l2_op_t OP_LOAD = 1'b0; // Read one word
	localparam l2_op_t OP_STORE = 1'b1; // Write one word, data echoed back

endpackage

// File: hw/l2_req_if.sv
`timescale 1ns/1ps

// Granted request, one cycle after the arbiter takes it
interface l2_req_if;

	logic valid; // One-cycle strobe per request
	l2_pkg::l2_core_t core; // Requesting core
	l2_pkg::l2_op_t op; // Load or store
	l2_pkg::l2_addr_t address; // Word address
	l2_pkg::l2_data_t data; // Store data, unused on loads

	// Arbiter side
	modport stage_out
	(
		output valid, core, op, address, data
	);

	// Memory side, always accepts so no ready
	modport stage_in
	(
		input valid, core, op, address, data
	);

endinterface

// File: hw/perf_counters.sv
`timescale 1ns/1ps

module perf_counters
(
	input logic clk,
	input logic reset,

	input logic [perf_pkg::NUM_COUNTERS-1:0] events, // One pulse bit per counter

	// Read port
	input perf_pkg::perf_index_t perf_index,
	output perf_pkg::perf_count_t perf_value
);

	perf_pkg::perf_count_t counts [perf_pkg::NUM_COUNTERS]; // Counter bank

	// Count event cycles, wrapping at COUNT_WIDTH
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
				counts[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
			begin
				if (events[i])
					counts[i] <= counts[i] + 1'b1; // Wraps naturally
			end
		end
	end

	// Combinational read mux
	assign perf_value = counts[perf_index];

endmodule

// File: hw/perf_pkg.sv
package perf_pkg;

	// Counter bank shape
	localparam int NUM_COUNTERS = 4; // One per event source
	localparam int COUNT_WIDTH = 16; // Wraps at this width

	typedef logic [COUNT_WIDTH-1:0] perf_count_t; // Counter value
	typedef logic [$clog2(NUM_COUNTERS)-1:0] perf_index_t; // Counter select

	// Event positions in the counter bank
	localparam int EV_LOAD = 0; // Load answered
	localparam int EV_STORE = 1; // Store answered
	localparam int EV_WAIT0 = 2; // Core 0 held off by arbiter
	localparam int EV_WAIT1 = 3; // Core 1 held off by arbiter

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
# Status comes from the search for the pass message in the simulation output

cd "$(dirname "$0")" &&
	verilator --binary --timing -j 0 \
		--top-module gpgpu_mem_tb \
		-f gpgpu_mem.f &&
	./obj_dir/Vgpgpu_mem_tb | tee /dev/stderr | grep -qF "ALL CHECKS PASSED" ||
	{ echo "simulation did not pass" >&2; exit 1; }

// File: tests/gpgpu_mem_patterns.txt
// Hex words: line count, then valid0 op0 address0 data0 valid1 op1 address1 data1 per line (op 1 = store)
// Closing four words: expected load, store, core 0 wait and core 1 wait counts
14
1 1 10 a0a00010 1 1 20 b1b10020
1 1 11 a0a00011 0 0 00 00000000
1 0 10 00000000 1 0 20 00000000
0 0 00 00000000 1 1 30 c1c10030
1 1 40 d0d00040 1 0 11 00000000
1 0 30 00000000 1 0 40 00000000
0 0 00 00000000 0 0 00 00000000
0 0 00 00000000 1 0 10 00000000
1 1 10 e0e00010 1 1 10 e1e10010
1 0 10 00000000 0 0 00 00000000
1 1 ff f0f000ff 1 1 00 f1f10000
1 0 00 00000000 1 0 ff 00000000
1 1 55 12345678 0 0 00 00000000
1 0 55 00000000 1 1 55 9abcdef0
0 0 00 00000000 1 0 55 00000000
1 0 55 00000000 1 1 aa 0badf00d
1 0 aa 00000000 1 0 aa 00000000
1 1 01 00000001 0 0 00 00000000
0 0 00 00000000 1 1 02 00000002
1 0 02 00000000 1 0 01 00000000
10
e
4
7

// File: tests/gpgpu_mem_tb.sv
`timescale 1ns/1ps

module gpgpu_mem_tb;

	localparam int TIMEOUT_CYCLES = 100; // Limit for every wait loop
	localparam int WORDS_PER_LINE = 8; // Four fields per core
	localparam int FILE_WORDS = 256; // Room for the pattern file

	// One predicted response
	typedef struct packed
	{
		logic [31:0] cycle; // Cycle count when rsp_valid is due
		l2_pkg::l2_core_t core;
		l2_pkg::l2_op_t op;
		l2_pkg::l2_addr_t address;
		l2_pkg::l2_data_t data;
	} rsp_item_t;

	logic clk;
	logic reset;
	logic req_valid0;
	l2_pkg::l2_op_t req_op0;
	l2_pkg::l2_addr_t req_address0;
	l2_pkg::l2_data_t req_data0;
	logic req_ready0;
	logic req_valid1;
	l2_pkg::l2_op_t req_op1;
	l2_pkg::l2_addr_t req_address1;
	l2_pkg::l2_data_t req_data1;
	logic req_ready1;
	logic rsp_valid;
	l2_pkg::l2_core_t rsp_core;
	l2_pkg::l2_op_t rsp_op;
	l2_pkg::l2_addr_t rsp_address;
	l2_pkg::l2_data_t rsp_data;
	perf_pkg::perf_index_t perf_index;
	perf_pkg::perf_count_t perf_value;

	logic [31:0] words [FILE_WORDS]; // Raw pattern file
	int line_count; // Stimulus lines in the file
	int unsigned cyc = 0; // Rising edges seen
	l2_pkg::l2_data_t model_mem [l2_pkg::MEM_WORDS]; // Reference memory
	logic model_written [l2_pkg::MEM_WORDS]; // Address has been stored
	logic model_prio; // Reference priority bit
	logic [31:0] model_counts [perf_pkg::NUM_COUNTERS]; // Reference counters
	rsp_item_t expected_q [$]; // Responses in flight with the oldest first

	gpgpu_mem_top gpgpu_mem_top_i
	(
		.clk(clk),
		.reset(reset),
		.req_valid0(req_valid0),
		.req_op0(req_op0),
		.req_address0(req_address0),
		.req_data0(req_data0),
		.req_ready0(req_ready0),
		.req_valid1(req_valid1),
		.req_op1(req_op1),
		.req_address1(req_address1),
		.req_data1(req_data1),
		.req_ready1(req_ready1),
		.rsp_valid(rsp_valid),
		.rsp_core(rsp_core),
		.rsp_op(rsp_op),
		.rsp_address(rsp_address),
		.rsp_data(rsp_data),
		.perf_index(perf_index),
		.perf_value(perf_value)
	);

	initial
		clk = 1'b0;
	always #10 clk = ~clk; // 20 ns period

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		stop_with_failure($sformatf("error: %s is 0x%h, expected 0x%h", name, got, expected));
	endtask

	// Put one core's request from the pattern words on its ports
	task automatic drive_core(input int core, input int base);
		if (core == 0)
		begin
			req_valid0 = words[base][0];
			req_op0 = words[base + 1][0];
			req_address0 = l2_pkg::l2_addr_t'(words[base + 2]);
			req_data0 = l2_pkg::l2_data_t'(words[base + 3]);
		end
		else
		begin
			req_valid1 = words[base][0];
			req_op1 = words[base + 1][0];
			req_address1 = l2_pkg::l2_addr_t'(words[base + 2]);
			req_data1 = l2_pkg::l2_data_t'(words[base + 3]);
		end
	endtask

	// Update the reference and queue the response for a request taken at the next edge
	task automatic predict_accept(input int core, input int base);
		rsp_item_t item;
		item.cycle = cyc + 2; // Arbiter register then response register
		item.core = l2_pkg::l2_core_t'(core);
		item.op = words[base + 1][0];
		item.address = l2_pkg::l2_addr_t'(words[base + 2]);
		if (item.op == l2_pkg::OP_STORE)
		begin
			item.data = l2_pkg::l2_data_t'(words[base + 3]); // Store data echoed
			model_mem[item.address] = item.data;
			model_written[item.address] = 1'b1;
			model_counts[perf_pkg::EV_STORE]++;
		end
		else
		begin
			if (!model_written[item.address])
				stop_with_failure("pattern file loads an address that was never stored");
			item.data = model_mem[item.address];
			model_counts[perf_pkg::EV_LOAD]++;
		end
		model_prio = ~item.core; // Loser goes next
		expected_q.push_back(item);
	endtask

	// Apply one line and hold each request until the arbiter takes it
	task automatic run_line(input int line);
		int base;
		int waited;
		logic pend0;
		logic pend1;
		logic grant0;
		logic grant1;
		base = 1 + line * WORDS_PER_LINE;
		pend0 = words[base][0];
		pend1 = words[base + 4][0];
		drive_core(0, base);
		drive_core(1, base + 4);
		waited = 0;
		while (pend0 || pend1)
		begin
			if (waited >= TIMEOUT_CYCLES)
				stop_with_failure($sformatf("timeout: requests of line %0d never taken", line));
			@(negedge clk);
			if (pend0 && pend1)
			begin
				grant0 = (model_prio == 1'b0); // Tie goes to the priority core
				grant1 = !grant0;
			end
			else
			begin
				grant0 = pend0; // Lone requester
				grant1 = pend1;
			end
			assert (req_ready0 == grant0)
			else value_error("req_ready0", 32'(req_ready0), 32'(grant0));
			assert (req_ready1 == grant1)
			else value_error("req_ready1", 32'(req_ready1), 32'(grant1));
			if (pend0 && !grant0)
				model_counts[perf_pkg::EV_WAIT0]++; // Held off this cycle
			if (pend1 && !grant1)
				model_counts[perf_pkg::EV_WAIT1]++;
			if (grant0)
				predict_accept(0, base);
			if (grant1)
				predict_accept(1, base + 4);
			@(posedge clk);
			#1;
			if (grant0)
			begin
				pend0 = 1'b0;
				req_valid0 = 1'b0;
			end
			if (grant1)
			begin
				pend1 = 1'b0;
				req_valid1 = 1'b0;
			end
			waited++;
		end
	endtask

	task automatic idle_cycles(input int count);
		repeat (count)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check_after_reset();
		for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
		begin
			perf_index = perf_pkg::perf_index_t'(i);
			@(negedge clk);
			assert (rsp_valid == 1'b0)
			else value_error("rsp_valid", 32'(rsp_valid), 32'h0);
			assert (perf_value == '0)
			else value_error($sformatf("perf_value[%0d]", i), 32'(perf_value), 32'h0);
			idle_cycles(1);
		end
	endtask

	task automatic wait_responses_drained();
		int waited;
		waited = 0;
		while (expected_q.size() > 0)
		begin
			if (waited >= TIMEOUT_CYCLES)
				stop_with_failure("timeout: responses still outstanding after the last request");
			@(posedge clk);
			waited++;
		end
		idle_cycles(2); // Last event lands in its counter one edge later
	endtask

	task automatic check_counters();
		int base;
		base = 1 + line_count * WORDS_PER_LINE;
		for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
		begin
			assert (model_counts[i] == words[base + i])
			else value_error($sformatf("expected perf_value[%0d] in patterns", i),
				words[base + i], model_counts[i]);
			perf_index = perf_pkg::perf_index_t'(i);
			@(negedge clk);
			assert (perf_value == perf_pkg::perf_count_t'(model_counts[i]))
			else value_error($sformatf("perf_value[%0d]", i), 32'(perf_value), model_counts[i]);
			idle_cycles(1);
		end
	endtask

	// Response bus monitor checks order, timing and payload
	always @(negedge clk)
	begin
		rsp_item_t due;
		if (!reset)
		begin
			if (rsp_valid)
			begin
				assert (expected_q.size() > 0)
				else stop_with_failure("rsp_valid high with no request in flight");
				due = expected_q.pop_front();
				assert (cyc == due.cycle)
				else value_error("rsp_valid cycle", cyc, due.cycle);
				assert (rsp_core == due.core)
				else value_error("rsp_core", 32'(rsp_core), 32'(due.core));
				assert (rsp_op == due.op)
				else value_error("rsp_op", 32'(rsp_op), 32'(due.op));
				assert (rsp_address == due.address)
				else value_error("rsp_address", 32'(rsp_address), 32'(due.address));
				assert (rsp_data == due.data)
				else value_error("rsp_data", rsp_data, due.data);
			end
			else if (expected_q.size() > 0)
			begin
				assert (cyc != expected_q[0].cycle)
				else stop_with_failure("rsp_valid stayed low in the cycle a response was due");
			end
		end
	end

	initial
	begin
		void'($urandom(32'h141e_7e71));
		reset = 1'b1;
		req_valid0 = 1'b0;
		req_op0 = l2_pkg::OP_LOAD;
		req_address0 = '0;
		req_data0 = '0;
		req_valid1 = 1'b0;
		req_op1 = l2_pkg::OP_LOAD;
		req_address1 = '0;
		req_data1 = '0;
		perf_index = '0;
		model_prio = 1'b0; // Core 0 first after reset
		for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
			model_counts[i] = '0;
		for (int a = 0; a < l2_pkg::MEM_WORDS; a++)
			model_written[a] = 1'b0;
		$readmemh("tests/gpgpu_mem_patterns.txt", words);
		if ($isunknown(words[0]) || words[0] == '0)
			stop_with_failure("pattern file missing or without a line count");
		line_count = int'(words[0]);
		if (1 + line_count * WORDS_PER_LINE + perf_pkg::NUM_COUNTERS > FILE_WORDS)
			stop_with_failure("pattern file holds more lines than the reader allows");
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		check_after_reset();
		for (int line = 0; line < line_count; line++)
		begin
			run_line(line);
			idle_cycles(int'($urandom_range(3, 0))); // Random gap between lines
		end
		wait_responses_drained();
		check_counters();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
